/* hdl/isa_pkg.sv */
package isa_pkg;

    // Major opcodes of the supported RV64 subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011
    } opcode_t;

    // funct3 selectors
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;
    localparam logic [2:0] funct3_ld      = 3'b011; // Doubleword load
    localparam logic [2:0] funct3_sd      = 3'b011; // Doubleword store

    localparam logic [6:0] funct7_sub = 7'b0100000; // SUB in OP space

    typedef logic [4:0] reg_idx_t;

    localparam reg_idx_t reg_zero = 5'd0; // x0, reads as zero

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

    // ALU operation carried from decode into execute
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_t;

    // Reason decode is held, in priority order
    typedef enum logic [1:0] {
        hz_none        = 2'd0,
        hz_raw_execute = 2'd1, // Source written by instruction in execute
        hz_raw_result  = 2'd2, // Source written by instruction in result
        hz_store_load  = 2'd3  // Load hits address of store in execute
    } hazard_t;

endpackage

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t ra1,
    input  isa_pkg::reg_idx_t ra2,
    input  logic              we,
    input  isa_pkg::reg_idx_t wa,
    input  logic [XLEN-1:0]   wd,
    output logic [XLEN-1:0]   rd1,
    output logic [XLEN-1:0]   rd2
);

    logic [XLEN-1:0] regs [32];

    // Write-first read, x0 tied low
    function automatic logic [XLEN-1:0] read_port(isa_pkg::reg_idx_t ra);
        if (ra == isa_pkg::reg_zero) begin
            return '0;
        end
        if (we && ra == wa) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != isa_pkg::reg_zero) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_port(ra1);
        rd2 = read_port(ra2);
    end

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  isa_pkg::reg_idx_t id_rs1,
    input  isa_pkg::reg_idx_t id_rs2,
    input  logic              id_use_rs1,
    input  logic              id_use_rs2,
    input  logic              id_load,
    input  logic [XLEN-1:0]   id_addr,
    input  isa_pkg::reg_idx_t ex_rd,
    input  logic              ex_we,
    input  logic              ex_store,
    input  logic [XLEN-1:0]   ex_store_addr,
    input  isa_pkg::reg_idx_t rs_rd,
    input  logic              rs_we,
    output logic              stall,
    output pipe_pkg::hazard_t cause
);

    logic raw_ex;
    logic raw_rs;
    logic st_ld;

    function automatic logic src_hit(isa_pkg::reg_idx_t rs, logic used,
                                     isa_pkg::reg_idx_t rd, logic we);
        return used && we && rs != isa_pkg::reg_zero && rs == rd;
    endfunction

    assign raw_ex = src_hit(id_rs1, id_use_rs1, ex_rd, ex_we) ||
                    src_hit(id_rs2, id_use_rs2, ex_rd, ex_we);
    assign raw_rs = src_hit(id_rs1, id_use_rs1, rs_rd, rs_we) ||
                    src_hit(id_rs2, id_use_rs2, rs_rd, rs_we);

    // Store-then-load on the same address
    // The bubble behind the stall moves the store on, so it lasts one cycle
    assign st_ld = id_load && ex_store && id_addr == ex_store_addr;

    always_comb begin
        if (!id_valid) begin
            cause = pipe_pkg::hz_none;
        end else if (raw_ex) begin
            cause = pipe_pkg::hz_raw_execute;
        end else if (raw_rs) begin
            cause = pipe_pkg::hz_raw_result;
        end else if (st_ld) begin
            cause = pipe_pkg::hz_store_load;
        end else begin
            cause = pipe_pkg::hz_none;
        end
    end

    assign stall = cause != pipe_pkg::hz_none;

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage #(
    parameter int XLEN       = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  logic [31:0]       inst,
    input  logic              stall,
    input  logic [XLEN-1:0]   rd1,
    input  logic [XLEN-1:0]   rd2,
    output isa_pkg::reg_idx_t ra1,
    output isa_pkg::reg_idx_t ra2,
    output logic              rs1_used,
    output logic              rs2_used,
    output logic              is_load,
    output logic [XLEN-1:0]   load_addr,
    output logic              ex_valid,
    output pipe_pkg::alu_op_t ex_alu_op,
    output logic [XLEN-1:0]   ex_a,
    output logic [XLEN-1:0]   ex_b,
    output isa_pkg::reg_idx_t ex_rd,
    output logic              ex_we,
    output logic              ex_load,
    output logic              ex_store,
    output logic [XLEN-1:0]   ex_store_data
);

    // Address bits that actually select a memory word
    localparam int              SPAN      = $clog2(DMEM_WORDS) + $clog2(XLEN / 8);
    localparam logic [XLEN-1:0] SPAN_MASK = {SPAN{1'b1}};

    isa_pkg::opcode_t  opcode;
    logic [2:0]        funct3;
    isa_pkg::reg_idx_t rd;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    pipe_pkg::alu_op_t alu_op;
    logic              alu_ok;
    logic              is_op;
    logic              is_op_imm;
    logic              is_store;
    logic              writes_rd;
    logic              accept;

    // ************************************************************
    // Field extraction
    // ************************************************************
    assign opcode = isa_pkg::opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign ra1    = inst[19:15];
    assign ra2    = inst[24:20];
    assign imm_i  = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s  = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        alu_op = pipe_pkg::alu_add;
        alu_ok = 1'b1;
        case (funct3)
            isa_pkg::funct3_add_sub: begin
                if (opcode == isa_pkg::opc_op && inst[31:25] == isa_pkg::funct7_sub) begin
                    alu_op = pipe_pkg::alu_sub;
                end
            end
            isa_pkg::funct3_xor: alu_op = pipe_pkg::alu_xor;
            isa_pkg::funct3_or:  alu_op = pipe_pkg::alu_or;
            isa_pkg::funct3_and: alu_op = pipe_pkg::alu_and;
            default:             alu_ok = 1'b0; // Shifts, compares
        endcase
    end

    assign is_op     = opcode == isa_pkg::opc_op && alu_ok;
    assign is_op_imm = opcode == isa_pkg::opc_op_imm && alu_ok;
    assign is_load   = opcode == isa_pkg::opc_load && funct3 == isa_pkg::funct3_ld;
    assign is_store  = opcode == isa_pkg::opc_store && funct3 == isa_pkg::funct3_sd;
    assign rs1_used  = is_op || is_op_imm || is_load || is_store;
    assign rs2_used  = is_op || is_store;
    assign writes_rd = (is_op || is_op_imm || is_load) && rd != isa_pkg::reg_zero;
    assign load_addr = (rd1 + imm_i) & SPAN_MASK; // For store-load check

    assign accept = inst_valid && !stall;

    // ************************************************************
    // Decode to execute register
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
        end else begin
            ex_valid <= accept; // Bubble when held or idle
            ex_we    <= accept && writes_rd;
            ex_load  <= accept && is_load;
            ex_store <= accept && is_store;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op     <= (is_op || is_op_imm) ? alu_op : pipe_pkg::alu_add;
        ex_a          <= rd1;
        ex_b          <= is_op ? rd2 : (is_store ? imm_s : imm_i);
        ex_rd         <= rd;
        ex_store_data <= rd2;
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage #(
    parameter int XLEN       = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    input  pipe_pkg::alu_op_t             ex_alu_op,
    input  logic [XLEN-1:0]               ex_a,
    input  logic [XLEN-1:0]               ex_b,
    input  isa_pkg::reg_idx_t             ex_rd,
    input  logic                          ex_we,
    input  logic                          ex_load,
    input  logic                          ex_store,
    input  logic [XLEN-1:0]               ex_store_data,
    input  logic [XLEN-1:0]               mem_rdata,
    output logic [$clog2(DMEM_WORDS)-1:0] mem_raddr,
    output logic [XLEN-1:0]               store_addr,
    output logic                          rs_valid,
    output isa_pkg::reg_idx_t             rs_rd,
    output logic                          rs_we,
    output logic                          rs_load,
    output logic                          rs_store,
    output logic [XLEN-1:0]               rs_alu_res,
    output logic [$clog2(DMEM_WORDS)-1:0] rs_addr,
    output logic [XLEN-1:0]               rs_store_data,
    output logic [XLEN-1:0]               rs_load_data
);

    localparam int              OFS       = $clog2(XLEN / 8); // Byte offset bits
    localparam int              AW        = $clog2(DMEM_WORDS);
    localparam logic [XLEN-1:0] SPAN_MASK = {(AW + OFS){1'b1}};

    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] addr;

    always_comb begin
        case (ex_alu_op)
            pipe_pkg::alu_sub: alu_res = ex_a - ex_b;
            pipe_pkg::alu_and: alu_res = ex_a & ex_b;
            pipe_pkg::alu_or:  alu_res = ex_a | ex_b;
            pipe_pkg::alu_xor: alu_res = ex_a ^ ex_b;
            default:           alu_res = ex_a + ex_b;
        endcase
    end

    assign addr       = ex_a + ex_b; // Base plus immediate
    assign store_addr = addr & SPAN_MASK;
    assign mem_raddr  = addr[OFS +: AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_valid <= 1'b0;
            rs_we    <= 1'b0;
            rs_load  <= 1'b0;
            rs_store <= 1'b0;
        end else begin
            rs_valid <= ex_valid;
            rs_we    <= ex_we;
            rs_load  <= ex_load;
            rs_store <= ex_store;
        end
    end

    always_ff @(posedge clk) begin
        rs_rd         <= ex_rd;
        rs_alu_res    <= alu_res;
        rs_addr       <= addr[OFS +: AW];
        rs_store_data <= ex_store_data;
        rs_load_data  <= mem_rdata; // Synchronous read point
    end

endmodule

/* hdl/result_stage.sv */
`timescale 1ns/100ps

module result_stage #(
    parameter int XLEN       = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rs_valid,
    input  isa_pkg::reg_idx_t             rs_rd,
    input  logic                          rs_we,
    input  logic                          rs_load,
    input  logic                          rs_store,
    input  logic [XLEN-1:0]               rs_alu_res,
    input  logic [$clog2(DMEM_WORDS)-1:0] rs_addr,
    input  logic [XLEN-1:0]               rs_store_data,
    input  logic [XLEN-1:0]               rs_load_data,
    input  logic [$clog2(DMEM_WORDS)-1:0] mem_raddr,
    output logic [XLEN-1:0]               mem_rdata,
    output logic                          rf_we,
    output isa_pkg::reg_idx_t             rf_wa,
    output logic [XLEN-1:0]               rf_wd,
    output logic                          wb_valid,
    output isa_pkg::reg_idx_t             wb_rd,
    output logic [XLEN-1:0]               wb_data
);

    logic [XLEN-1:0] dmem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (rs_valid && rs_store) begin
            dmem[rs_addr] <= rs_store_data;
        end
    end

    assign mem_rdata = dmem[mem_raddr]; // Captured by execute

    assign rf_we = rs_valid && rs_we;
    assign rf_wa = rs_rd;
    assign rf_wd = rs_load ? rs_load_data : rs_alu_res;

    // Write-back pulse, x0 writes stay silent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rf_we && rs_rd != isa_pkg::reg_zero;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= rf_wa;
        wb_data <= rf_wd;
    end

endmodule

/* hdl/pipe_top.sv */
`timescale 1ns/100ps

module pipe_top #(
    parameter int XLEN       = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  logic [31:0]       inst,
    output logic              inst_stall,
    output pipe_pkg::hazard_t hazard,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_rd,
    output logic [XLEN-1:0]   wb_data
);

    // ************************************************************
    // Stage wiring
    // ************************************************************
    isa_pkg::reg_idx_t               ra1, ra2, ex_rd, rs_rd, rf_wa;
    logic [XLEN-1:0]                 rd1, rd2, load_addr, store_addr;
    logic                            rs1_used, rs2_used, is_load;
    logic                            ex_valid, ex_we, ex_load, ex_store;
    pipe_pkg::alu_op_t               ex_alu_op;
    logic [XLEN-1:0]                 ex_a, ex_b, ex_store_data;
    logic [$clog2(DMEM_WORDS)-1:0]   mem_raddr, rs_addr;
    logic [XLEN-1:0]                 mem_rdata;
    logic                            rs_valid, rs_we, rs_load, rs_store;
    logic [XLEN-1:0]                 rs_alu_res, rs_store_data, rs_load_data;
    logic                            rf_we;
    logic [XLEN-1:0]                 rf_wd;

    reg_file #(.XLEN(XLEN)) i_reg_file (
        .we (rf_we),
        .wa (rf_wa),
        .wd (rf_wd),
        .*
    );

    hazard_unit #(.XLEN(XLEN)) i_hazard_unit (
        .id_valid      (inst_valid),
        .id_rs1        (ra1),
        .id_rs2        (ra2),
        .id_use_rs1    (rs1_used),
        .id_use_rs2    (rs2_used),
        .id_load       (is_load),
        .id_addr       (load_addr),
        .ex_store_addr (store_addr),
        .stall         (inst_stall),
        .cause         (hazard),
        .*
    );

    decode_stage #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) i_decode_stage (
        .stall (inst_stall),
        .*
    );

    execute_stage #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) i_execute_stage (.*);

    result_stage #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) i_result_stage (.*);

endmodule

/* verif/pipe_asserts.sv */
`timescale 1ns/100ps

module pipe_asserts (
    input logic              clk,
    input logic              rst_n,
    input logic              id_valid,
    input isa_pkg::reg_idx_t id_rs1,
    input isa_pkg::reg_idx_t id_rs2,
    input logic              ex_we,
    input logic              ex_store,
    input logic              stall,
    input pipe_pkg::hazard_t cause
);

    // Source keeps a held instruction in place
    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> id_valid && $stable(id_rs1) && $stable(id_rs2)
    ) else $error("Held instruction dropped or changed while stalled");

    // Store moves on after one cycle
    a_store_load_once: assert property (
        @(posedge clk) disable iff (!rst_n)
        cause == pipe_pkg::hz_store_load |=> cause != pipe_pkg::hz_store_load
    ) else $error("Store-load stall held for more than one cycle");

    // Held cycle leaves a bubble in execute
    a_bubble_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> !ex_we && !ex_store
    ) else $error("Stalled instruction reached execute");

endmodule

bind hazard_unit pipe_asserts i_pipe_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_valid (id_valid),
    .id_rs1   (id_rs1),
    .id_rs2   (id_rs2),
    .ex_we    (ex_we),
    .ex_store (ex_store),
    .stall    (stall),
    .cause    (cause)
);

/* verif/pipe_tb.sv */
`timescale 1ns/100ps

module pipe_tb;

    localparam int PERIOD      = 100;
    localparam int DRIVE_DELAY = 10;

    typedef struct {
        int          gap;
        logic [31:0] word;
        int          wb;
        int          rd;
        logic [63:0] data;
        int          stalls;
        int          hz;
    } pattern_t;

    logic              clk;
    logic              rst_n;
    logic              inst_valid;
    logic [31:0]       inst;
    logic              inst_stall;
    pipe_pkg::hazard_t hazard;
    logic              wb_valid;
    isa_pkg::reg_idx_t wb_rd;
    logic [63:0]       wb_data;

    pattern_t          patterns[$];
    isa_pkg::reg_idx_t exp_rd[$];
    logic [63:0]       exp_data[$];
    logic [15:0]       lfsr;
    bit                loaded = 1'b0;

    pipe_top i_pipe_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_stall (inst_stall),
        .hazard     (hazard),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ************************************************************
    // Helpers
    // ************************************************************
    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, string want, string got);
        fail_run($sformatf("Mismatch at %0t: %s expected %s got %s", $time, name, want, got));
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int random_gap();
        int g;
        g = 0;
        for (int i = 0; i < 2; i++) begin
            g = (g << 1) | int'(next_random_bit());
        end
        return g;
    endfunction

    // Producer leaves execute for result after one held cycle
    function automatic pipe_pkg::hazard_t expected_cause(int first, int cycle);
        if (cycle > 0 && first == int'(pipe_pkg::hz_raw_execute)) begin
            return pipe_pkg::hz_raw_result;
        end
        return pipe_pkg::hazard_t'(first);
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        pattern_t    p;
        int          gap, wb, rd, stalls, hz;
        logic [31:0] word;
        logic [63:0] data;
        fd = $fopen("verif/pipe_patterns.txt", "r");
        assert (fd != 0) else fail_run("Could not open the pattern file verif/pipe_patterns.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%d %h %d %d %h %d %d", gap, word, wb, rd, data, stalls, hz);
            if (n == 7) begin // Header lines fail the scan
                p.gap    = gap;
                p.word   = word;
                p.wb     = wb;
                p.rd     = rd;
                p.data   = data;
                p.stalls = stalls;
                p.hz     = hz;
                patterns.push_back(p);
            end
        end
        $fclose(fd);
        assert (patterns.size() > 0) else fail_run("The pattern file holds no patterns");
    endtask

    task automatic idle_cycles(int n);
        inst_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Present one word and hold it until decode takes it
    task automatic send_pattern(int idx);
        int                stalls;
        bit                accepted;
        pipe_pkg::hazard_t want;
        stalls     = 0;
        accepted   = 1'b0;
        inst_valid = 1'b1;
        inst       = patterns[idx].word;
        while (!accepted) begin
            @(negedge clk);
            if (inst_stall) begin
                want = expected_cause(patterns[idx].hz, stalls);
                assert (hazard == want) else report_mismatch("hazard", want.name(), hazard.name());
                stalls++;
            end else begin
                accepted = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        assert (stalls == patterns[idx].stalls) else
            report_mismatch($sformatf("inst_stall cycles of pattern %0d", idx),
                            $sformatf("%0d", patterns[idx].stalls), $sformatf("%0d", stalls));
        if (patterns[idx].wb != 0) begin
            exp_rd.push_back(isa_pkg::reg_idx_t'(patterns[idx].rd));
            exp_data.push_back(patterns[idx].data);
        end
    endtask

    task automatic check_idle();
        assert (!inst_stall) else report_mismatch("inst_stall", "0", $sformatf("%b", inst_stall));
        assert (!wb_valid) else report_mismatch("wb_valid", "0", $sformatf("%b", wb_valid));
        assert (hazard == pipe_pkg::hz_none) else
            report_mismatch("hazard", "hz_none", hazard.name());
    endtask

    // ************************************************************
    // Write-back monitor
    // ************************************************************
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            assert (exp_rd.size() > 0) else
                fail_run($sformatf("Write-back to x%0d at %0t arrived with none expected",
                                   wb_rd, $time));
            assert (wb_rd == exp_rd[0]) else
                report_mismatch("wb_rd", $sformatf("%0d", exp_rd[0]), $sformatf("%0d", wb_rd));
            assert (wb_data == exp_data[0]) else
                report_mismatch("wb_data", $sformatf("%h", exp_data[0]),
                                $sformatf("%h", wb_data));
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end
    end

    initial begin
        wait (loaded);
        #((patterns.size() * 8 + 20) * PERIOD);
        fail_run("Timeout, write-backs stopped arriving before all patterns completed");
    end

    // ************************************************************
    // Main sequence
    // ************************************************************
    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        lfsr       = 16'd7080;
        load_patterns();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle(); // Nothing issued yet
        @(posedge clk);
        #DRIVE_DELAY;
        foreach (patterns[i]) begin
            if (patterns[i].gap != 0) begin
                idle_cycles(random_gap());
            end
            send_pattern(i);
        end
        inst_valid = 1'b0;
        repeat (4) @(posedge clk); // Last write-back lands two edges after acceptance
        assert (exp_rd.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected write-backs never arrived", exp_rd.size()));
        end
    end

endmodule

/* verif/pipe_patterns.txt */
# gap inst wb rd data stalls hz
# gap 1 allows an idle gap before the line, hz is the cause in the first stall cycle
1 12300093 1 1  0000000000000123 0 0
1 fff00113 1 2  ffffffffffffffff 0 0
1 05500193 1 3  0000000000000055 0 0
1 00700013 0 0  0000000000000000 0 0
0 00900293 1 5  0000000000000009 0 0
1 00308333 1 6  0000000000000178 0 0
0 401303b3 1 7  0000000000000055 2 1
0 0023c433 1 8  ffffffffffffffaa 2 1
1 001174b3 1 9  0000000000000123 0 0
0 0051e533 1 10 000000000000005d 0 0
0 006485b3 1 11 000000000000029b 1 2
0 ff058613 1 12 000000000000028b 2 1
1 00803823 0 0  0000000000000000 0 0
0 01003683 1 13 ffffffffffffffaa 1 3
1 00603c23 0 0  0000000000000000 0 0
0 01003703 1 14 ffffffffffffffaa 0 0
0 01803783 1 15 0000000000000178 0 0
0 00d78833 1 16 0000000000000122 2 1
1 7ff00893 1 17 00000000000007ff 0 0
1 40100933 1 18 fffffffffffffedd 0 0
0 0128e9b3 1 19 ffffffffffffffff 2 1
1 00d84a33 1 20 fffffffffffffe88 0 0
1 01188ab3 1 21 0000000000000ffe 0 0
1 03303023 0 0  0000000000000000 0 0
0 02003b03 1 22 ffffffffffffffff 1 3
1 414a8bb3 1 23 0000000000001176 0 0
0 017b0c33 1 24 0000000000001175 2 1

/* build.f */
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipe_top.sv
verif/pipe_asserts.sv
verif/pipe_tb.sv

/* Makefile */
BIN := obj_dir/Vpipe_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module pipe_tb -Mdir obj_dir -f build.f

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
